// File: qa_pkg.sv
package qa_pkg;

   // ========================================================================
   // Widths with a meaning
   // ========================================================================

   // One host cache line of 64 bytes
   typedef logic [511:0] line_t;

   // Host addresses are counted in cache lines, not bytes
   typedef logic [31:0] line_addr_t;

   // Line offset inside the device status memory
   typedef logic [9:0] dsm_offset_t;

   // Index written by software to select a debug dump
   typedef logic [7:0] debug_idx_t;

   // ========================================================================
   // Write channel
   // ========================================================================

   // Write request types understood by the transmit channel
   typedef enum logic [1:0] {
      WrLine = 2'd0,
      WrThru = 2'd1
   } req_type_e;

   typedef struct packed {
      req_type_e  request_type;
      line_addr_t address;
   } write_header_t;

   // What a requester offers to the write arbiter, held until granted
   typedef struct packed {
      logic          request;
      write_header_t header;
      line_t         data;
   } write_req_t;

   typedef struct packed {
      logic status_grant;
      logic ext_grant;
   } write_grant_t;

   // Registered line sent to the transmit channel
   typedef struct packed {
      logic          valid;
      write_header_t header;
      line_t         data;
   } tx_line_t;

   // ========================================================================
   // Configuration, debug and receive records
   // ========================================================================

   // The trigger is nonzero for exactly one cycle per software request
   typedef struct packed {
      line_addr_t dsm_base;
      logic       dsm_base_valid;
      debug_idx_t trigger_debug;
   } afu_csr_t;

   // Debug record sized so that the index byte completes a full line
   typedef struct packed {
      logic [31:0]  rx_count;
      logic [31:0]  rx_last_addr;
      logic [31:0]  rx_xor;
      logic [407:0] pad;
   } debug_rsp_t;

   // One incoming read response line
   typedef struct packed {
      logic       valid;
      line_addr_t addr;
      line_t      data;
   } rx_line_t;

   // Word 0 holds ACED0000 up to word 3 holding ACED0003, all others are zero
   localparam line_t AFU_ID = {384'h0, 32'haced0003, 32'haced0002,
                               32'haced0001, 32'haced0000};

   // Convert a DSM line offset into a host line address
   function automatic line_addr_t dsm_offset2addr(input dsm_offset_t offset,
                                                  input line_addr_t  base);
      return base + line_addr_t'(offset);
   endfunction

endpackage

// File: afu_csr.sv
`timescale 1ns/1ps

module afu_csr (
   input  logic            clk,
   input  logic            resetb,
   input  logic            csr_write,
   input  logic [3:0]      csr_addr,
   input  logic [31:0]     csr_data,
   output qa_pkg::afu_csr_t csr
);

   import qa_pkg::*;

   // Word addresses of the registers that this block decodes
   localparam logic [3:0] CSR_DSM_BASE      = 4'd1;
   localparam logic [3:0] CSR_TRIGGER_DEBUG = 4'd2;

   line_addr_t dsm_base;
   logic       dsm_base_valid;
   debug_idx_t trigger_debug;

   // Strobes decoded from the register write
   logic write_base;
   logic write_trigger;

   assign write_base    = csr_write && (csr_addr == CSR_DSM_BASE);
   assign write_trigger = csr_write && (csr_addr == CSR_TRIGGER_DEBUG);

   // ========================================================================
   // DSM base address
   // ========================================================================

   // Host line address of the DSM, loaded by a base register write
   always_ff @(posedge clk) begin
      if (write_base) begin
         dsm_base <= csr_data;
      end
   end

   // Once software has set the base it stays valid until the next reset
   always_ff @(posedge clk) begin
      if (!resetb) begin
         dsm_base_valid <= 1'b0;
      end else if (write_base) begin
         dsm_base_valid <= 1'b1;
      end
   end

   // ========================================================================
   // Debug trigger
   // ========================================================================

   // A write of index zero means no request, so it never makes a pulse
   // The pulse lasts one cycle and drops back to zero on its own
   always_ff @(posedge clk) begin
      if (!resetb) begin
         trigger_debug <= '0;
      end else if (write_trigger && (csr_data[7:0] != 8'h00)) begin
         trigger_debug <= csr_data[7:0];
      end else begin
         trigger_debug <= '0;
      end
   end

   // Writes to all other addresses fall through with no effect
   // Every effect is visible one cycle after the strobe
   assign csr = '{
      dsm_base:       dsm_base,
      dsm_base_valid: dsm_base_valid,
      trigger_debug:  trigger_debug
   };

endmodule

// File: frame_reader.sv
`timescale 1ns/1ps

module frame_reader (
   input  logic               clk,
   input  logic               resetb,
   input  qa_pkg::rx_line_t   rx,
   output qa_pkg::debug_rsp_t dbg_rsp
);

   import qa_pkg::*;

   // Running statistics over all response lines since reset
   logic [31:0] rx_count;
   line_addr_t  rx_last_addr;
   logic [31:0] rx_xor;

   // ========================================================================
   // Statistics
   // ========================================================================

   // Every valid line bumps the count by one
   always_ff @(posedge clk) begin
      if (!resetb) begin
         rx_count <= '0;
      end else if (rx.valid) begin
         rx_count <= rx_count + 32'd1;
      end
   end

   // The address of the most recent line, zero until one arrives
   always_ff @(posedge clk) begin
      if (!resetb) begin
         rx_last_addr <= '0;
      end else if (rx.valid) begin
         rx_last_addr <= rx.addr;
      end
   end

   // A cheap checksum over the low word of each line
   // Only word 0 is folded in, which is enough to tell lines apart in a dump
   always_ff @(posedge clk) begin
      if (!resetb) begin
         rx_xor <= '0;
      end else if (rx.valid) begin
         rx_xor <= rx_xor ^ rx.data[31:0];
      end
   end

   // ========================================================================
   // Debug record
   // ========================================================================

   // The status writer puts its index byte above this record
   // Updates from a line show here one cycle after its valid cycle
   assign dbg_rsp = '{
      rx_count:     rx_count,
      rx_last_addr: rx_last_addr,
      rx_xor:       rx_xor,
      pad:          '0
   };

endmodule

// File: status_writer.sv
`timescale 1ns/1ps

module status_writer (
   input  logic                 clk,
   input  logic                 resetb,
   input  qa_pkg::afu_csr_t     csr,
   input  qa_pkg::write_grant_t write_grant,
   input  qa_pkg::debug_rsp_t   dbg_frame_reader,
   output qa_pkg::write_req_t   status_req
);

   import qa_pkg::*;

   // INIT sends the accelerator ID, DEBUG sends one dump, IDLE waits
   typedef enum logic [1:0] {
      STATE_INIT,
      STATE_IDLE,
      STATE_DEBUG
   } state_t;

   // Every status line goes to line 0 of the DSM
   localparam dsm_offset_t STATUS_OFFSET = '0;

   // Debug index that selects the frame reader record
   localparam debug_idx_t DBG_FRAME_READER = 8'd1;

   state_t     state;
   state_t     next_state;
   debug_idx_t debug_req;
   debug_rsp_t debug_rsp;
   line_t      debug_line;

   // ========================================================================
   // Debug dump
   // ========================================================================

   // Software may not trigger again before the dump leaves, so the index
   // only has to be caught once per dump
   always_ff @(posedge clk) begin
      if ((state == STATE_IDLE) && (csr.trigger_debug != '0)) begin
         debug_req <= csr.trigger_debug;
      end
   end

   // Unknown indexes report an all-zero record
   always_comb begin
      case (debug_req)
         DBG_FRAME_READER: debug_rsp = dbg_frame_reader;
         default:          debug_rsp = '0;
      endcase
   end

   // Index in the top byte, the selected record below it
   assign debug_line = {debug_req, debug_rsp};

   // ========================================================================
   // FSM
   // ========================================================================

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state <= STATE_INIT;
      end else begin
         state <= next_state;
      end
   end

   // Only one line is in flight at a time
   // A trigger is noticed only while nothing else is pending
   always_comb begin
      next_state = state;
      if (write_grant.status_grant) begin
         next_state = STATE_IDLE;
      end else if ((state == STATE_IDLE) && (csr.trigger_debug != '0)) begin
         next_state = STATE_DEBUG;
      end
   end

   // ========================================================================
   // Write request
   // ========================================================================

   // Nothing may be written until software has told us where the DSM lives
   // The request stays up until the arbiter grants it
   assign status_req.request             = (state != STATE_IDLE) && csr.dsm_base_valid;
   assign status_req.header.request_type = WrLine;
   assign status_req.header.address      = dsm_offset2addr(STATUS_OFFSET, csr.dsm_base);
   assign status_req.data                = (state == STATE_DEBUG) ? debug_line : AFU_ID;

endmodule

// File: write_arbiter.sv
`timescale 1ns/1ps

module write_arbiter (
   input  logic                 clk,
   input  logic                 resetb,
   input  qa_pkg::write_req_t   status_req,
   input  qa_pkg::write_req_t   ext_req,
   input  logic                 tx_almost_full,
   output qa_pkg::write_grant_t write_grant,
   output qa_pkg::tx_line_t     tx
);

   import qa_pkg::*;

   logic          status_grant;
   logic          ext_grant;
   logic          any_grant;
   write_req_t    winner;

   // Registered transmit line
   logic          tx_valid;
   write_header_t tx_header;
   line_t         tx_data;

   // ========================================================================
   // Grant
   // ========================================================================

   // Status traffic is rare and short, so it always goes first
   // Almost-full blocks both sides and the requests simply wait
   assign status_grant = status_req.request && !tx_almost_full;
   assign ext_grant    = ext_req.request && !tx_almost_full && !status_grant;
   assign any_grant    = status_grant || ext_grant;

   assign write_grant = '{
      status_grant: status_grant,
      ext_grant:    ext_grant
   };

   // Pick the granted request for the transmit register
   assign winner = status_grant ? status_req : ext_req;

   // ========================================================================
   // Transmit register
   // ========================================================================

   // The line leaves exactly one cycle after its grant
   always_ff @(posedge clk) begin
      if (!resetb) begin
         tx_valid <= 1'b0;
      end else begin
         tx_valid <= any_grant;
      end
   end

   // Header and data only load on a grant, so they hold between lines
   always_ff @(posedge clk) begin
      if (any_grant) begin
         tx_header <= winner.header;
         tx_data   <= winner.data;
      end
   end

   assign tx = '{
      valid:  tx_valid,
      header: tx_header,
      data:   tx_data
   };

endmodule

// File: qa_top.sv
`timescale 1ns/1ps

module qa_top (
   input  logic               clk,
   input  logic               resetb,
   input  logic               csr_write,
   input  logic [3:0]         csr_addr,
   input  logic [31:0]        csr_data,
   input  qa_pkg::rx_line_t   rx,
   input  qa_pkg::write_req_t ext_req,
   output logic               ext_grant,
   input  logic               tx_almost_full,
   output qa_pkg::tx_line_t   tx
);

   import qa_pkg::*;

   afu_csr_t     csr;
   write_grant_t write_grant;
   debug_rsp_t   dbg_frame_reader;
   write_req_t   status_req;

   // Register writes from software, giving the DSM base and debug trigger
   afu_csr u_afu_csr (
      .clk       (clk),
      .resetb    (resetb),
      .csr_write (csr_write),
      .csr_addr  (csr_addr),
      .csr_data  (csr_data),
      .csr       (csr)
   );

   // Statistics over incoming read responses
   frame_reader u_frame_reader (
      .clk     (clk),
      .resetb  (resetb),
      .rx      (rx),
      .dbg_rsp (dbg_frame_reader)
   );

   // Accelerator ID after reset, one debug dump per trigger
   status_writer u_status_writer (
      .clk              (clk),
      .resetb           (resetb),
      .csr              (csr),
      .write_grant      (write_grant),
      .dbg_frame_reader (dbg_frame_reader),
      .status_req       (status_req)
   );

   // Status and external writes share the transmit channel
   write_arbiter u_write_arbiter (
      .clk            (clk),
      .resetb         (resetb),
      .status_req     (status_req),
      .ext_req        (ext_req),
      .tx_almost_full (tx_almost_full),
      .write_grant    (write_grant),
      .tx             (tx)
   );

   // The external requester needs its grant to drop its request
   assign ext_grant = write_grant.ext_grant;

endmodule

// File: qa_asserts.sv
`timescale 1ns/1ps

module qa_asserts (
   input logic                 clk,
   input logic                 resetb,
   input logic                 tx_almost_full,
   input qa_pkg::write_grant_t write_grant,
   input qa_pkg::tx_line_t     tx
);

   // Count of assertion failures since the start of the run
   int failures = 0;

   // Fixed priority means at most one requester wins per cycle
   one_grant: assert property (@(posedge clk) disable iff (!resetb)
      !(write_grant.status_grant && write_grant.ext_grant))
   else begin
      failures++;
      $error("Status and external grants high together");
   end

   // Almost-full holds both requesters off
   no_grant_when_full: assert property (@(posedge clk) disable iff (!resetb)
      tx_almost_full |-> !(write_grant.status_grant || write_grant.ext_grant))
   else begin
      failures++;
      $error("Grant given while tx_almost_full is high");
   end

   // The transmit register loads the winner on the grant edge
   grant_then_valid: assert property (@(posedge clk) disable iff (!resetb)
      (write_grant.status_grant || write_grant.ext_grant) |=> tx.valid)
   else begin
      failures++;
      $error("Grant not followed by tx valid");
   end

endmodule

bind write_arbiter qa_asserts u_asserts (
   .clk            (clk),
   .resetb         (resetb),
   .tx_almost_full (tx_almost_full),
   .write_grant    (write_grant),
   .tx             (tx)
);

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
   input logic             clk,
   input qa_pkg::tx_line_t tx
);

   import qa_pkg::*;

   // Lines that the testbench expects on tx, oldest first
   write_header_t exp_header[$];
   line_t         exp_data[$];

   // Read by the testbench to follow progress and build the closing line
   int errors     = 0;
   int lines_seen = 0;

   write_header_t want_header;
   line_t         want_data;

   // The testbench calls this when it drives something that must produce a line
   task automatic push_expected(input write_header_t header, input line_t data);
      exp_header.push_back(header);
      exp_data.push_back(data);
   endtask

   // ========================================================================
   // Line compare
   // ========================================================================

   // tx is registered, so half a cycle after the edge it is stable
   always @(negedge clk) begin
      if (tx.valid === 1'b1) begin
         lines_seen++;
         if (exp_header.size() == 0) begin
            errors++;
            $display("A tx line to address %h was sent at %0t while no line was expected",
                     tx.header.address, $time);
         end else begin
            want_header = exp_header.pop_front();
            want_data   = exp_data.pop_front();
            if (tx.header.request_type !== want_header.request_type) begin
               errors++;
               $display("FAILED %0t tx.header.request_type got %0d expected %0d",
                        $time, tx.header.request_type, want_header.request_type);
            end
            if (tx.header.address !== want_header.address) begin
               errors++;
               $display("FAILED %0t tx.header.address got %h expected %h",
                        $time, tx.header.address, want_header.address);
            end
            if (tx.data !== want_data) begin
               errors++;
               $display("FAILED %0t tx.data got %h expected %h",
                        $time, tx.data, want_data);
            end
         end
      end
   end

   // Anything still queued at the end is a line the DUT never sent
   task automatic report_leftover();
      if (exp_header.size() != 0) begin
         errors++;
         $display("%0d expected tx lines were never sent", exp_header.size());
      end
   endtask

endmodule

// File: tb_qa.sv
`timescale 1ns/1ps

module tb_qa;

   import qa_pkg::*;

   // Operations that one row of the stimulus table can perform
   typedef enum logic [2:0] {OP_CSR, OP_RX, OP_EXT, OP_AFULL, OP_IDLE, OP_RESET} op_e;

   // Which tx line, if any, the row produces
   typedef enum logic [1:0] {EXP_NONE, EXP_ID, EXP_DEBUG, EXP_EXT} exp_e;

   // Wait_sent holds the row until every queued line left, lat is the exact
   // cycle count from the drive to the line, zero when it is not fixed
   typedef struct packed {
      op_e         op;
      logic [31:0] arg;
      logic [31:0] data;
      exp_e        exp;
      logic        wait_sent;
      logic [3:0]  lat;
   } row_t;

   logic       clk;
   logic       resetb;
   logic       csr_write;
   logic [3:0] csr_addr;
   logic [31:0] csr_data;
   rx_line_t   rx;
   write_req_t ext_req;
   logic       ext_grant;
   logic       tx_almost_full;
   tx_line_t   tx;

   row_t        rows[$];
   logic        table_ready = 1'b0;
   logic [31:0] lcg_state;
   logic        ext_drop;
   int          pushed;
   int          seq_errors;

   // Reference copy of the base and the rx statistics, kept from what was sent
   line_addr_t  model_base;
   logic [31:0] model_count;
   logic [31:0] model_last;
   logic [31:0] model_xor;

   qa_top dut (
      .clk            (clk),
      .resetb         (resetb),
      .csr_write      (csr_write),
      .csr_addr       (csr_addr),
      .csr_data       (csr_data),
      .rx             (rx),
      .ext_req        (ext_req),
      .ext_grant      (ext_grant),
      .tx_almost_full (tx_almost_full),
      .tx             (tx)
   );

   tb_checker chk (
      .clk (clk),
      .tx  (tx)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ========================================================================
   // Expected values
   // ========================================================================

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic line_t random_line();
      line_t l;
      for (int k = 0; k < 16; k++) begin
         l[32*k +: 32] = lcg_next();
      end
      return l;
   endfunction

   // Words 0 to 3 carry ACED0000 to ACED0003, the rest of the line is zero
   function automatic line_t id_line();
      line_t l;
      l = '0;
      for (int k = 0; k < 4; k++) begin
         l[32*k +: 32] = 32'haced0000 + 32'(k);
      end
      return l;
   endfunction

   // Index 1 reports the rx statistics, every other index an empty record
   function automatic line_t debug_line(input debug_idx_t idx);
      if (idx == 8'd1) begin
         return {idx, model_count, model_last, model_xor, 408'h0};
      end
      return {idx, 504'h0};
   endfunction

   // ========================================================================
   // Stimulus table
   // ========================================================================

   function automatic void add_row(input op_e op, input logic [31:0] arg,
                                   input logic [31:0] data, input exp_e exp,
                                   input logic wait_sent, input logic [3:0] lat);
      row_t r;
      r.op        = op;
      r.arg       = arg;
      r.data      = data;
      r.exp       = exp;
      r.wait_sent = wait_sent;
      r.lat       = lat;
      rows.push_back(r);
   endfunction

   task automatic build_table();
      // Quiet until the base is set, an unknown address is ignored
      add_row(OP_IDLE,  4,             0,             EXP_NONE,  0, 0);
      add_row(OP_CSR,   3,             32'h1234,      EXP_NONE,  0, 0);
      add_row(OP_IDLE,  3,             0,             EXP_NONE,  0, 0);
      add_row(OP_CSR,   1,             32'h0004_0000, EXP_ID,    1, 2);
      add_row(OP_IDLE,  2,             0,             EXP_NONE,  0, 0);
      // External writes pass straight through
      add_row(OP_EXT,   32'h100,       0,             EXP_EXT,   1, 1);
      add_row(OP_EXT,   32'h101,       0,             EXP_EXT,   1, 1);
      add_row(OP_EXT,   32'h102,       0,             EXP_EXT,   1, 1);
      // Frame reader dump, then a zero index that must not trigger
      add_row(OP_RX,    32'h2000,      0,             EXP_NONE,  0, 0);
      add_row(OP_RX,    32'h2001,      0,             EXP_NONE,  0, 0);
      add_row(OP_RX,    32'h2002,      0,             EXP_NONE,  0, 0);
      add_row(OP_RX,    32'h2003,      0,             EXP_NONE,  0, 0);
      add_row(OP_CSR,   2,             1,             EXP_DEBUG, 1, 3);
      add_row(OP_CSR,   2,             0,             EXP_NONE,  0, 0);
      add_row(OP_IDLE,  3,             0,             EXP_NONE,  0, 0);
      // Unknown index gives an empty record
      add_row(OP_CSR,   2,             5,             EXP_DEBUG, 1, 3);
      // Both requests wait behind almost-full, status leaves first
      add_row(OP_AFULL, 1,             0,             EXP_NONE,  0, 0);
      add_row(OP_CSR,   2,             1,             EXP_DEBUG, 0, 0);
      add_row(OP_EXT,   32'h200,       0,             EXP_EXT,   0, 0);
      add_row(OP_IDLE,  6,             0,             EXP_NONE,  0, 0);
      // Status is granted in the release cycle and external in the next one
      add_row(OP_AFULL, 0,             0,             EXP_NONE,  1, 2);
      // Reset in the middle clears the base flag and the statistics
      add_row(OP_RESET, 3,             0,             EXP_NONE,  0, 0);
      add_row(OP_IDLE,  4,             0,             EXP_NONE,  0, 0);
      add_row(OP_RX,    32'h3000,      0,             EXP_NONE,  0, 0);
      add_row(OP_RX,    32'h3001,      0,             EXP_NONE,  0, 0);
      add_row(OP_CSR,   1,             32'h0008_0000, EXP_ID,    1, 2);
      add_row(OP_CSR,   2,             1,             EXP_DEBUG, 1, 3);
   endtask

   // ========================================================================
   // Drive
   // ========================================================================

   // A granted external request is dropped at the next drive point
   task automatic sample_grant();
      if (ext_req.request && ext_grant) begin
         ext_drop = 1'b1;
      end
   endtask

   // One-cycle strobes fall back here, 1 ns after the edge
   task automatic advance();
      @(posedge clk);
      #1;
      csr_write = 1'b0;
      rx.valid  = 1'b0;
      if (ext_drop) begin
         ext_req.request = 1'b0;
         ext_drop        = 1'b0;
      end
   endtask

   task automatic queue_expected(input write_header_t h, input line_t d);
      pushed++;
      chk.push_expected(h, d);
   endtask

   task automatic wait_for_lines(input int lat);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < 20) begin
         @(negedge clk);
         #1;
         sample_grant();
         if (chk.lines_seen >= pushed) begin
            seen = 1'b1;
         end else begin
            advance();
            cycles++;
         end
      end
      if (!seen) begin
         seq_errors++;
         $display("An expected tx line did not arrive within 20 cycles at %0t", $time);
      end else begin
         if (lat != 0 && cycles != lat) begin
            seq_errors++;
            $display("FAILED %0t tx latency got %0d expected %0d", $time, cycles, lat);
         end
         advance();
      end
   endtask

   task automatic apply_row(input row_t r);
      write_header_t h;
      line_t         d;
      h.request_type = WrLine;
      h.address      = model_base;
      case (r.op)
         OP_CSR: begin
            csr_write = 1'b1;
            csr_addr  = r.arg[3:0];
            csr_data  = r.data;
            if (r.arg[3:0] == 4'd1) begin
               model_base = r.data;
            end
            h.address = model_base;
            if (r.exp == EXP_ID) begin
               queue_expected(h, id_line());
            end else if (r.exp == EXP_DEBUG) begin
               queue_expected(h, debug_line(r.data[7:0]));
            end
         end
         OP_RX: begin
            d        = random_line();
            rx.valid = 1'b1;
            rx.addr  = r.arg;
            rx.data  = d;
            model_count = model_count + 32'd1;
            model_last  = r.arg;
            model_xor   = model_xor ^ d[31:0];
         end
         OP_EXT: begin
            d              = random_line();
            h.request_type = WrThru;
            h.address      = r.arg;
            ext_req.request = 1'b1;
            ext_req.header  = h;
            ext_req.data    = d;
            if (r.exp == EXP_EXT) begin
               queue_expected(h, d);
            end
         end
         OP_AFULL: tx_almost_full = r.arg[0];
         OP_RESET: begin
            resetb         = 1'b0;
            ext_req        = '0;
            ext_drop       = 1'b0;
            tx_almost_full = 1'b0;
            model_count    = '0;
            model_last     = '0;
            model_xor      = '0;
         end
         default: ;
      endcase
   endtask

   task automatic run_row(input row_t r);
      apply_row(r);
      if (r.op == OP_RESET) begin
         repeat (r.arg) advance();
         resetb = 1'b1;
      end else if (r.wait_sent) begin
         wait_for_lines(int'(r.lat));
      end else begin
         repeat ((r.op == OP_IDLE) ? r.arg : 1) begin
            @(negedge clk);
            #1;
            sample_grant();
            advance();
         end
      end
   endtask

   // ========================================================================
   // Run control
   // ========================================================================

   initial begin
      wait (table_ready);
      repeat (20 * rows.size() + 100) @(posedge clk);
      $display("Watchdog expired, the run did not finish in time");
      $display("Test failed");
      $finish;
   end

   initial begin
      int total;
      int assert_fails;
      resetb         = 1'b0;
      csr_write      = 1'b0;
      csr_addr       = '0;
      csr_data       = '0;
      rx             = '0;
      ext_req        = '0;
      tx_almost_full = 1'b0;
      ext_drop       = 1'b0;
      lcg_state      = 32'd26538;
      model_base     = '0;
      model_count    = '0;
      model_last     = '0;
      model_xor      = '0;
      pushed         = 0;
      seq_errors     = 0;
      build_table();
      table_ready = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      resetb = 1'b1;
      foreach (rows[i]) begin
         run_row(rows[i]);
      end
      // A few quiet cycles catch any stray line
      repeat (5) begin
         @(negedge clk);
         #1;
         sample_grant();
         advance();
      end
      chk.report_leftover();
      assert_fails = dut.u_write_arbiter.u_asserts.failures;
      total = seq_errors + chk.errors + assert_fails;
      $display("Errors: %0d total, %0d checker, %0d sequence, %0d assertion",
               total, chk.errors, seq_errors, assert_fails);
      if (total == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: sim.f
qa_pkg.sv
afu_csr.sv
frame_reader.sv
status_writer.sv
write_arbiter.sv
qa_top.sv
qa_asserts.sv
tb_checker.sv
tb_qa.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_qa -f sim.f -o tb_qa_sim

# A failed run still leaves its log for the search below
./obj_dir/tb_qa_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
   exit 0
else
   exit 1
fi
